// ==== build.f ====
rtl/smem_pkg.sv
rtl/read_loader.sv
rtl/read_ram.sv
rtl/read_issue.sv
rtl/query_extract.sv
rtl/read_buffer_top.sv
dv/tb_read_buffer.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the read buffer testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f build.f --top-module tb_read_buffer -o sim_read_buffer

./obj_dir/sim_read_buffer > sim.log 2>&1
cat sim.log

if grep -qF '*** TEST FAILED ***' sim.log; then
	exit 1
fi
exit 0

// ==== dv/tb_read_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_read_buffer import smem_pkg::*; ();

	localparam int CLK_PERIOD  = 40;
	localparam int NUM_QUERIES = 200;
	localparam int MAX_CYCLES  = 1500; // 80 beats with gaps, 20 reads issued, 203 query cycles

	logic clk, reset_n, load_valid, load_done, new_read, new_read_valid;
	logic [CL-1:0]         load_data;
	logic [READ_NUM_W-1:0] batch_size, new_read_num, query_read_num;
	logic [FIELD_W-1:0]    new_ik_x0, new_ik_x1, new_ik_x2, new_ik_info;
	logic [FIELD_W-1:0]    primary, l2_0, l2_1, l2_2, l2_3;
	logic [POS_W-1:0]      new_forward_i, query_position;
	logic [BASE_W-1:0]     new_read_query;
	status_t               status_query;

	// model of the four banks
	logic [CL-1:0] m_read_1 [MAX_READ];
	logic [CL-1:0] m_read_2 [MAX_READ];
	logic [CL-1:0] m_param  [MAX_READ];
	logic [CL-1:0] m_ik     [MAX_READ];
	logic [BASE_W-1:0] exp_q [$]; // expected query results in issue order

	integer seed;
	int     errors;
	int     cycles;
	logic   done_expected;

	read_buffer_top dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic int rand_below(input int n);
		return ($random(seed) & 32'h7fff_ffff) % n;
	endfunction

	function automatic logic [CL-1:0] rand_word();
		logic [CL-1:0] w;
		for (int k = 0; k < CL / 32; k++) begin
			w[k*32 +: 32] = $random(seed);
		end
		return w;
	endfunction

	function automatic status_t live_status(input int kind);
		case (kind)
			2, 3:    return F_INIT;
			4, 5:    return F_RUN;
			6:       return B_INIT;
			default: return B_RUN;
		endcase
	endfunction

	task automatic mismatch(input string test_name, input logic [63:0] expv,
				input logic [63:0] actv);
		errors++;
		$display("Mismatch %s: expected %h, actual %h", test_name, expv, actv);
	endtask

	task automatic fail(input string what);
		errors++;
		$display("Error: %s", what);
	endtask

	// nothing may be done or on offer while beats are still arriving
	task automatic check_idle();
		@(negedge clk);
		if (load_done !== 1'b0) fail("load_done high before the final ik beat");
		if (new_read_valid !== 1'b0) fail("new_read_valid high before load_done");
	endtask

	task automatic load_batch();
		logic [CL-1:0] beat;
		for (int r = 0; r < int'(batch_size); r++) begin
			m_read_1[r] = rand_word();
			m_read_2[r] = rand_word();
			m_param[r]  = rand_word();
			m_ik[r]     = rand_word();
			for (int b = 0; b < 4; b++) begin
				case (b)
					0:       beat = m_read_1[r];
					1:       beat = m_read_2[r];
					2:       beat = m_param[r];
					default: beat = m_ik[r];
				endcase
				repeat (rand_below(3)) begin
					@(posedge clk);
					load_valid <= 1'b0;
					check_idle();
				end
				@(posedge clk);
				load_valid <= 1'b1;
				load_data  <= beat;
				check_idle();
			end
		end
		@(posedge clk); // final ik beat is written here
		load_valid <= 1'b0;
	endtask

	task automatic check_issue(input logic [READ_NUM_W-1:0] num);
		if (new_read_valid !== 1'b1) fail($sformatf("read %0d was not offered", num));
		if (new_read_num !== num) mismatch("issue read_num", 64'(num), 64'(new_read_num));
		if (new_ik_x0 !== m_ik[num][63:0]) mismatch("issue ik_x0", m_ik[num][63:0], new_ik_x0);
		if (new_ik_x1 !== m_ik[num][127:64]) mismatch("issue ik_x1", m_ik[num][127:64], new_ik_x1);
		if (new_ik_x2 !== m_ik[num][191:128]) mismatch("issue ik_x2", m_ik[num][191:128], new_ik_x2);
		if (new_ik_info !== m_ik[num][255:192])
			mismatch("issue ik_info", m_ik[num][255:192], new_ik_info);
		if (new_forward_i !== m_param[num][6:0])
			mismatch("issue forward_i", 64'(m_param[num][6:0]), 64'(new_forward_i));
	endtask

	// after the last read the outputs fall back to the fill pattern
	task automatic check_drained(input string when);
		@(negedge clk);
		if (new_read_valid !== 1'b0) fail({"new_read_valid still high ", when});
		if (new_read_num !== 9'h1FF) mismatch({when, " read_num"}, 64'h1FF, 64'(new_read_num));
		if (new_ik_x0 !== 64'h1111_1111_1111_1111)
			mismatch({when, " ik_x0"}, 64'h1111_1111_1111_1111, new_ik_x0);
		if (new_ik_x1 !== 64'h1111_1111_1111_1111)
			mismatch({when, " ik_x1"}, 64'h1111_1111_1111_1111, new_ik_x1);
		if (new_ik_x2 !== 64'h1111_1111_1111_1111)
			mismatch({when, " ik_x2"}, 64'h1111_1111_1111_1111, new_ik_x2);
		if (new_ik_info !== 64'h1111_1111_1111_1111)
			mismatch({when, " ik_info"}, 64'h1111_1111_1111_1111, new_ik_info);
		if (new_forward_i !== 7'h7F) mismatch({when, " forward_i"}, 64'h7F, 64'(new_forward_i));
	endtask

	task automatic run_queries();
		logic [BASE_W-1:0] expq;
		logic [POS_W-1:0]  pos;
		logic [POS_W-1:0]  live_pos;
		logic [2*CL-1:0]   bases;
		int                kind;
		int                rnum;
		live_pos = '0;
		for (int j = 0; j < NUM_QUERIES + 3; j++) begin
			@(posedge clk);
			if (j < NUM_QUERIES) begin
				kind = rand_below(8);
				rnum = rand_below(int'(batch_size));
				query_read_num <= READ_NUM_W'(rnum);
				if (kind < 2) begin
					pos = POS_W'(rand_below(128));
					status_query <= (kind == 0) ? BUBBLE : F_BREAK;
					exp_q.push_back(8'hFF);
				end else begin
					pos      = live_pos; // live queries sweep every position
					live_pos = live_pos + 1'b1;
					status_query <= live_status(kind);
					bases = {m_read_2[rnum], m_read_1[rnum]};
					exp_q.push_back(bases[pos*8 +: 8]);
				end
				query_position <= pos;
			end else begin
				status_query <= BUBBLE;
				exp_q.push_back(8'hFF);
			end
			@(negedge clk);
			expq = (j < 3) ? 8'hFF : exp_q.pop_front(); // result lags its query by 3 drives
			if (new_read_query !== expq)
				mismatch($sformatf("query %0d", j - 3), 64'(expq), 64'(new_read_query));
		end
	endtask

	always @(negedge clk) begin
		if (done_expected && load_done !== 1'b1)
			fail("load_done dropped after the batch was loaded");
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles, errors: %0d",
				MAX_CYCLES, errors);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	initial begin
		seed           = 72;
		errors         = 0;
		cycles         = 0;
		done_expected  = 1'b0;
		reset_n        = 1'b0;
		load_valid     = 1'b0;
		load_data      = '0;
		new_read       = 1'b0;
		status_query   = BUBBLE;
		query_position = '0;
		query_read_num = '0;
		batch_size     = READ_NUM_W'(1 + rand_below(20));
		repeat (4) @(posedge clk);
		reset_n <= 1'b1;

		@(posedge clk);
		new_read <= 1'b1; // nothing on offer yet, must be ignored
		@(posedge clk);
		new_read <= 1'b0;

		load_batch();
		@(negedge clk); // read_count has just reached batch_size
		if (load_done !== 1'b0) fail("load_done rose in the cycle of the final ik beat");
		@(negedge clk);
		if (load_done !== 1'b1) fail("load_done did not rise one cycle after the final ik beat");
		if (new_read_valid !== 1'b0) fail("new_read_valid rose together with load_done");
		done_expected = 1'b1;

		if (primary !== m_param[0][191:128]) mismatch("primary", m_param[0][191:128], primary);
		if (l2_0 !== m_ik[0][319:256]) mismatch("l2_0", m_ik[0][319:256], l2_0);
		if (l2_1 !== m_ik[0][383:320]) mismatch("l2_1", m_ik[0][383:320], l2_1);
		if (l2_2 !== m_ik[0][447:384]) mismatch("l2_2", m_ik[0][447:384], l2_2);
		if (l2_3 !== m_ik[0][511:448]) mismatch("l2_3", m_ik[0][511:448], l2_3);

		for (int i = 0; i < int'(batch_size); i++) begin
			repeat (rand_below(3)) @(posedge clk); // host back-pressure
			@(negedge clk);
			check_issue(READ_NUM_W'(i));
			@(posedge clk);
			new_read <= 1'b1;
			@(posedge clk);
			new_read <= 1'b0;
		end
		check_drained("after last read");

		run_queries();
		$display("reads: %0d, queries: %0d, errors: %0d", batch_size, NUM_QUERIES, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== rtl/read_buffer_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module read_buffer_top import smem_pkg::*; (
	input  logic                  clk,
	input  logic                  reset_n,
	input  logic                  load_valid,
	input  logic [CL-1:0]         load_data,
	input  logic [READ_NUM_W-1:0] batch_size,
	output logic                  load_done,
	input  logic                  new_read,
	output logic                  new_read_valid,
	output logic [READ_NUM_W-1:0] new_read_num,
	output logic [FIELD_W-1:0]    new_ik_x0,
	output logic [FIELD_W-1:0]    new_ik_x1,
	output logic [FIELD_W-1:0]    new_ik_x2,
	output logic [FIELD_W-1:0]    new_ik_info,
	output logic [POS_W-1:0]      new_forward_i,
	input  status_t               status_query,
	input  logic [POS_W-1:0]      query_position,
	input  logic [READ_NUM_W-1:0] query_read_num,
	output logic [BASE_W-1:0]     new_read_query,
	output logic [FIELD_W-1:0]    primary,
	output logic [FIELD_W-1:0]    l2_0,
	output logic [FIELD_W-1:0]    l2_1,
	output logic [FIELD_W-1:0]    l2_2,
	output logic [FIELD_W-1:0]    l2_3
);

	logic                  wr_en;
	bank_t                 wr_bank;
	logic [READ_NUM_W-1:0] wr_addr;
	logic [CL-1:0]         wr_data;
	logic [READ_NUM_W-1:0] read_count;
	logic [READ_NUM_W-1:0] issue_addr;
	logic [READ_NUM_W-1:0] query_addr;
	logic [CL-1:0]         issue_ik;
	logic [CL-1:0]         issue_param;
	logic [CL-1:0]         query_read_1;
	logic [CL-1:0]         query_read_2;

	read_loader loader_i (
		.clk, .reset_n, .load_valid, .load_data, .batch_size,
		.wr_en, .wr_bank, .wr_addr, .wr_data, .read_count, .load_done
	);

	read_ram ram_i (
		.clk, .wr_en, .wr_bank, .wr_addr, .wr_data, .issue_addr, .query_addr,
		.issue_ik, .issue_param, .query_read_1, .query_read_2,
		.primary, .l2_0, .l2_1, .l2_2, .l2_3
	);

	read_issue issue_i (
		.clk, .reset_n, .load_done, .read_count, .new_read, .issue_ik, .issue_param,
		.issue_addr, .new_read_valid, .new_read_num,
		.new_ik_x0, .new_ik_x1, .new_ik_x2, .new_ik_info, .new_forward_i
	);

	query_extract query_i (
		.clk, .reset_n, .status_query, .query_position, .query_read_num,
		.query_read_1, .query_read_2, .query_addr, .new_read_query
	);

endmodule

`default_nettype wire

// ==== rtl/query_extract.sv ====
`timescale 1ns/100ps
`default_nettype none

module query_extract import smem_pkg::*; (
	input  logic                  clk,
	input  logic                  reset_n,
	input  status_t               status_query,
	input  logic [POS_W-1:0]      query_position,
	input  logic [READ_NUM_W-1:0] query_read_num,
	input  logic [CL-1:0]         query_read_1,
	input  logic [CL-1:0]         query_read_2,
	output logic [READ_NUM_W-1:0] query_addr,
	output logic [BASE_W-1:0]     new_read_query
);

	logic [2*CL-1:0]    read_bases; // base p is byte p
	logic               query_live;

	status_t            status_s1;
	logic [HALF_W-1:0]  sel_s1;
	logic [4:0]         pos_s1;

	status_t            status_s2;
	logic [FIELD_W-1:0] sel_s2;
	logic [2:0]         pos_s2;

	// ram is read asynchronously, so the read number goes straight out
	assign query_addr = query_read_num;
	assign read_bases = {query_read_2, query_read_1};

	// a break never enters the pipe
	assign query_live = (status_query != BUBBLE) && (status_query != F_BREAK);

	// stage 1: 128 bases down to 32
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			status_s1 <= BUBBLE;
		end else begin
			status_s1 <= query_live ? status_query : BUBBLE;
		end
	end

	always_ff @(posedge clk) begin
		if (query_live) begin
			sel_s1 <= read_bases[query_position[6:5] * HALF_W +: HALF_W];
			pos_s1 <= query_position[4:0];
		end
	end

	// stage 2: 32 bases down to 8
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			status_s2 <= BUBBLE;
		end else begin
			status_s2 <= status_s1;
		end
	end

	always_ff @(posedge clk) begin
		if (status_s1 != BUBBLE) begin
			sel_s2 <= sel_s1[pos_s1[4:3] * FIELD_W +: FIELD_W];
			pos_s2 <= pos_s1[2:0];
		end
	end

	// stage 3: pick the byte, bubbles come out as NO_BASE
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			new_read_query <= NO_BASE;
		end else if (status_s2 != BUBBLE) begin
			new_read_query <= sel_s2[pos_s2 * BASE_W +: BASE_W];
		end else begin
			new_read_query <= NO_BASE;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/read_issue.sv ====
`timescale 1ns/100ps
`default_nettype none

module read_issue import smem_pkg::*; (
	input  logic                  clk,
	input  logic                  reset_n,
	input  logic                  load_done,
	input  logic [READ_NUM_W-1:0] read_count,
	input  logic                  new_read,
	input  logic [CL-1:0]         issue_ik,
	input  logic [CL-1:0]         issue_param,
	output logic [READ_NUM_W-1:0] issue_addr,
	output logic                  new_read_valid,
	output logic [READ_NUM_W-1:0] new_read_num,
	output logic [FIELD_W-1:0]    new_ik_x0,
	output logic [FIELD_W-1:0]    new_ik_x1,
	output logic [FIELD_W-1:0]    new_ik_x2,
	output logic [FIELD_W-1:0]    new_ik_info,
	output logic [POS_W-1:0]      new_forward_i
);

	logic [READ_NUM_W-1:0] read_ptr;
	logic [READ_NUM_W-1:0] ptr_next;
	logic [ISSUE_W-1:0]    live_bundle;

	// a pulse only counts while a read is on offer
	assign ptr_next = read_ptr + {{(READ_NUM_W-1){1'b0}}, new_read & new_read_valid};

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			read_ptr       <= '0;
			new_read_valid <= 1'b0;
		end else begin
			read_ptr       <= ptr_next;
			new_read_valid <= load_done && (ptr_next < read_count); // last read included
		end
	end

	assign issue_addr = read_ptr;

	// ik fields are x0, x1, x2, info from the bottom up
	assign live_bundle = {
		read_ptr,
		issue_ik[3*FIELD_W +: FIELD_W],
		issue_ik[2*FIELD_W +: FIELD_W],
		issue_ik[FIELD_W +: FIELD_W],
		issue_ik[0 +: FIELD_W],
		issue_param[POS_W-1:0]
	};

	assign {new_read_num, new_ik_info, new_ik_x2, new_ik_x1, new_ik_x0, new_forward_i} =
		new_read_valid ? live_bundle : NO_READ_FILL;

endmodule

`default_nettype wire

// ==== rtl/read_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

module read_ram import smem_pkg::*; (
	input  logic                  clk,
	input  logic                  wr_en,
	input  bank_t                 wr_bank,
	input  logic [READ_NUM_W-1:0] wr_addr,
	input  logic [CL-1:0]         wr_data,
	input  logic [READ_NUM_W-1:0] issue_addr,
	input  logic [READ_NUM_W-1:0] query_addr,
	output logic [CL-1:0]         issue_ik,
	output logic [CL-1:0]         issue_param,
	output logic [CL-1:0]         query_read_1,
	output logic [CL-1:0]         query_read_2,
	output logic [FIELD_W-1:0]    primary,
	output logic [FIELD_W-1:0]    l2_0,
	output logic [FIELD_W-1:0]    l2_1,
	output logic [FIELD_W-1:0]    l2_2,
	output logic [FIELD_W-1:0]    l2_3
);

	// one entry per read in each bank
	logic [CL-1:0] mem_read_1 [MAX_READ];
	logic [CL-1:0] mem_read_2 [MAX_READ];
	logic [CL-1:0] mem_param  [MAX_READ];
	logic [CL-1:0] mem_ik     [MAX_READ];

	// single write port, the bank comes from the loader arbiter
	always_ff @(posedge clk) begin
		if (wr_en) begin
			case (wr_bank)
				BANK_READ_1: mem_read_1[wr_addr] <= wr_data;
				BANK_READ_2: mem_read_2[wr_addr] <= wr_data;
				BANK_PARAM:  mem_param[wr_addr]  <= wr_data;
				BANK_IK:     mem_ik[wr_addr]     <= wr_data;
				default: ;
			endcase
		end
	end

	// issue side reads the interval and parameter words
	assign issue_ik    = mem_ik[issue_addr];
	assign issue_param = mem_param[issue_addr];

	// query side reads the base words
	assign query_read_1 = mem_read_1[query_addr];
	assign query_read_2 = mem_read_2[query_addr];

	// batch constants live in entry 0
	assign primary = mem_param[0][2*FIELD_W +: FIELD_W];
	assign l2_0    = mem_ik[0][4*FIELD_W +: FIELD_W];
	assign l2_1    = mem_ik[0][5*FIELD_W +: FIELD_W];
	assign l2_2    = mem_ik[0][6*FIELD_W +: FIELD_W];
	assign l2_3    = mem_ik[0][7*FIELD_W +: FIELD_W];

endmodule

`default_nettype wire

// ==== rtl/read_loader.sv ====
`timescale 1ns/100ps
`default_nettype none

module read_loader import smem_pkg::*; (
	input  logic                  clk,
	input  logic                  reset_n,
	input  logic                  load_valid,
	input  logic [CL-1:0]         load_data,
	input  logic [READ_NUM_W-1:0] batch_size,
	output logic                  wr_en,
	output bank_t                 wr_bank,
	output logic [READ_NUM_W-1:0] wr_addr,
	output logic [CL-1:0]         wr_data,
	output logic [READ_NUM_W-1:0] read_count,
	output logic                  load_done
);

	bank_t                 arbiter;  // bank for the next beat
	logic [READ_NUM_W-1:0] read_idx; // read being filled

	// beats go straight through, only the destination is tracked here
	assign wr_en   = load_valid;
	assign wr_bank = arbiter;
	assign wr_addr = read_idx;
	assign wr_data = load_data;

	// every complete read has had its ik beat
	assign read_count = read_idx;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			arbiter  <= BANK_READ_1;
			read_idx <= '0;
		end else if (load_valid) begin
			arbiter <= bank_t'(arbiter + 2'd1); // wraps ik -> read_1
			if (arbiter == BANK_IK) begin
				read_idx <= read_idx + 1'b1;
			end
		end
	end

	// sticky until reset
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			load_done <= 1'b0;
		end else if (read_idx == batch_size && batch_size != '0) begin
			load_done <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/smem_pkg.sv ====
`default_nettype none

package smem_pkg;

	localparam int CL         = 512; // storage word and load beat width
	localparam int MAX_READ   = 512; // reads per bank
	localparam int READ_NUM_W = 9;
	localparam int POS_W      = 7;   // 128 bases over two base words
	localparam int FIELD_W    = 64;  // ik, primary and l2 fields
	localparam int HALF_W     = CL / 2;
	localparam int BASE_W     = 8;

	// per-query status carried down the extraction pipeline
	typedef enum logic [5:0] {
		F_INIT  = 6'd0,
		F_RUN   = 6'd1,
		F_BREAK = 6'd2,
		B_INIT  = 6'd3,
		B_RUN   = 6'd4,
		BUBBLE  = 6'b110000
	} status_t;

	// destination of a load beat, in arrival order
	typedef enum logic [1:0] {
		BANK_READ_1,
		BANK_READ_2,
		BANK_PARAM,
		BANK_IK
	} bank_t;

	// issue bundle is {read_num, info, x2, x1, x0, forward_i}
	localparam int ISSUE_W = READ_NUM_W + 4 * FIELD_W + POS_W;

	localparam logic [ISSUE_W-1:0] NO_READ_FILL = {
		{READ_NUM_W{1'b1}},
		{4{64'h1111_1111_1111_1111}},
		{POS_W{1'b1}}
	};

	localparam logic [BASE_W-1:0] NO_BASE = 8'hFF;

endpackage

`default_nettype wire
